/* hdl/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    // Base opcodes of RV32I
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    // funct3 of OP and OP-IMM
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // funct3 of the branches
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // funct7 selecting SUB and SRA
    localparam logic [6:0] F7_ALT = 7'b0100000;

    // First fetch address after reset
    localparam logic [31:0] RESET_PC = 32'h0000_0000;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_e;

    // Fetch to decode
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] instr;
    } fetch_s;

    // Decode to execute
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [4:0]  rd;
        logic [31:0] imm;
        logic [31:0] rs1_val;
        logic [31:0] rs2_val;
        alu_op_e     alu_op;
        logic        a_is_pc;
        logic        b_is_imm;
        logic        is_branch;
        logic        is_jal;
        logic        is_jalr;
        logic        writes_rd;
        logic        illegal;
        logic [2:0]  funct3;
    } decode_s;

    // One completed instruction
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [4:0]  rd;
        logic [31:0] value;
        logic        we;
        logic        illegal;
    } retire_s;

    // Wishbone classic, master side
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic [31:0] adr;
    } wb_req_s;

    // Wishbone classic, slave side
    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_s;

endpackage

`default_nettype wire

/* hdl/rv_regfile.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_regfile (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic [4:0]  rs1_addr_i,
    input  logic [4:0]  rs2_addr_i,
    output logic [31:0] rs1_data_o,
    output logic [31:0] rs2_data_o,
    input  logic        we_i,
    input  logic [4:0]  rd_i,
    input  logic [31:0] wd_i
);

    // x1 to x31, x0 has no storage
    logic [31:0] regs_q [1:31];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= 32'b0;
            end
        end else if (we_i && rd_i != 5'd0) begin
            regs_q[rd_i] <= wd_i;
        end
    end

    // Asynchronous reads
    always_comb begin
        if (rs1_addr_i == 5'd0) begin
            rs1_data_o = 32'b0;
        end else begin
            rs1_data_o = regs_q[rs1_addr_i];
        end
    end

    always_comb begin
        if (rs2_addr_i == 5'd0) begin
            rs2_data_o = 32'b0;
        end else begin
            rs2_data_o = regs_q[rs2_addr_i];
        end
    end

endmodule

`default_nettype wire

/* hdl/rv_fetch.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_fetch
    import rv_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        redirect_valid_i,
    input  logic [31:0] redirect_pc_i,
    input  wb_rsp_s     wb_rsp_i,
    output wb_req_s     wb_req_o,
    output fetch_s      fetch_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_DISCARD
    } fetch_state_e;

    fetch_state_e state_q;

    // Next sequential fetch address
    logic [31:0] pc_q;
    // Address held on the bus for the read in flight
    logic [31:0] adr_q;
    logic        fvalid_q;
    logic [31:0] fpc_q;
    logic [31:0] finstr_q;

    // Request is high in both bus states
    assign wb_req_o.cyc = (state_q != ST_IDLE);
    assign wb_req_o.stb = (state_q != ST_IDLE);
    assign wb_req_o.adr = adr_q;

    assign fetch_o.valid = fvalid_q;
    assign fetch_o.pc    = fpc_q;
    assign fetch_o.instr = finstr_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q  <= ST_IDLE;
            pc_q     <= RESET_PC;
            fvalid_q <= 1'b0;
        end else begin
            // Word to decode lasts a single cycle
            fvalid_q <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    // Bus idle for one cycle between reads
                    state_q <= ST_REQ;
                end
                ST_REQ: begin
                    if (wb_rsp_i.ack) begin
                        state_q <= ST_IDLE;
                        if (redirect_valid_i) begin
                            // Stale word, drop it
                            pc_q <= redirect_pc_i;
                        end else begin
                            fvalid_q <= 1'b1;
                            pc_q     <= adr_q + 32'd4;
                        end
                    end else if (redirect_valid_i) begin
                        // Let the read finish, then throw it away
                        state_q <= ST_DISCARD;
                        pc_q    <= redirect_pc_i;
                    end
                end
                ST_DISCARD: begin
                    if (redirect_valid_i) begin
                        pc_q <= redirect_pc_i;
                    end
                    if (wb_rsp_i.ack) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Address and fetched word
    always_ff @(posedge clk_i) begin
        if (state_q == ST_IDLE) begin
            adr_q <= redirect_valid_i ? redirect_pc_i : pc_q;
        end
        if (state_q == ST_REQ && wb_rsp_i.ack) begin
            fpc_q    <= adr_q;
            finstr_q <= wb_rsp_i.dat;
        end
    end

    // Classic handshake holds the request until ack
    a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (wb_req_o.stb && !wb_rsp_i.ack) |=> (wb_req_o.stb && $stable(wb_req_o.adr)));

    // A word for decode only comes out of an acked read
    a_fetch_ack: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(fetch_o.valid) |-> $past(wb_rsp_i.ack));

endmodule

`default_nettype wire

/* hdl/rv_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_decode
    import rv_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  fetch_s      fetch_i,
    input  logic        flush_i,
    output logic [4:0]  rs1_addr_o,
    output logic [4:0]  rs2_addr_o,
    input  logic [31:0] rs1_data_i,
    input  logic [31:0] rs2_data_i,
    input  logic        wb_we_i,
    input  logic [4:0]  wb_rd_i,
    input  logic [31:0] wb_value_i,
    output decode_s     dec_o
);

    logic [31:0] instr;
    logic [6:0]  opcode;
    logic [6:0]  fun7;
    logic [2:0]  fun3;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] imm;
    logic [31:0] rs1_val;
    logic [31:0] rs2_val;
    decode_s     dec_d;
    decode_s     dec_q;
    logic        valid_q;

    // Instruction fields
    assign instr  = fetch_i.instr;
    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign fun3   = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign fun7   = instr[31:25];

    assign rs1_addr_o = rs1;
    assign rs2_addr_o = rs2;

    // Immediate by instruction format
    always_comb begin
        case (opcode)
            OPC_OP_IMM, OPC_LOAD, OPC_JALR:
                imm = {{21{instr[31]}}, instr[30:20]};
            OPC_STORE:
                imm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
            // B-type, bit 0 always zero
            OPC_BRANCH:
                imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            OPC_LUI, OPC_AUIPC:
                imm = {instr[31:12], 12'b0};
            // J-type, 21-bit signed offset
            OPC_JAL:
                imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            default:
                imm = 32'b0;
        endcase
    end

    // Execute write in this cycle wins over the register file
    assign rs1_val = (wb_we_i && wb_rd_i == rs1) ? wb_value_i : rs1_data_i;
    assign rs2_val = (wb_we_i && wb_rd_i == rs2) ? wb_value_i : rs2_data_i;

    // Control decode
    always_comb begin
        dec_d           = '0;
        dec_d.valid     = fetch_i.valid;
        dec_d.pc        = fetch_i.pc;
        dec_d.rd        = rd;
        dec_d.imm       = imm;
        dec_d.rs1_val   = rs1_val;
        dec_d.rs2_val   = rs2_val;
        dec_d.funct3    = fun3;
        dec_d.alu_op    = ALU_ADD;
        case (opcode)
            OPC_OP, OPC_OP_IMM: begin
                dec_d.b_is_imm  = (opcode == OPC_OP_IMM);
                dec_d.writes_rd = 1'b1;
                case (fun3)
                    // SUB only exists in the register form
                    F3_ADD:  dec_d.alu_op = (opcode == OPC_OP && fun7 == F7_ALT) ?
                                            ALU_SUB : ALU_ADD;
                    F3_SLL:  dec_d.alu_op = ALU_SLL;
                    F3_SLT:  dec_d.alu_op = ALU_SLT;
                    F3_SLTU: dec_d.alu_op = ALU_SLTU;
                    F3_XOR:  dec_d.alu_op = ALU_XOR;
                    F3_SR:   dec_d.alu_op = (fun7 == F7_ALT) ? ALU_SRA : ALU_SRL;
                    F3_OR:   dec_d.alu_op = ALU_OR;
                    default: dec_d.alu_op = ALU_AND;
                endcase
            end
            OPC_LUI: begin
                dec_d.alu_op    = ALU_PASS_B;
                dec_d.b_is_imm  = 1'b1;
                dec_d.writes_rd = 1'b1;
            end
            OPC_AUIPC: begin
                dec_d.a_is_pc   = 1'b1;
                dec_d.b_is_imm  = 1'b1;
                dec_d.writes_rd = 1'b1;
            end
            OPC_JAL: begin
                dec_d.is_jal    = 1'b1;
                dec_d.writes_rd = 1'b1;
            end
            OPC_JALR: begin
                dec_d.is_jalr   = 1'b1;
                dec_d.writes_rd = 1'b1;
            end
            OPC_BRANCH: begin
                // funct3 010 and 011 are not branches
                dec_d.is_branch = (fun3[2:1] != 2'b01);
                dec_d.illegal   = (fun3[2:1] == 2'b01);
            end
            // Loads, stores and unknown opcodes
            default: dec_d.illegal = 1'b1;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= fetch_i.valid && !flush_i;
        end
    end

    always_ff @(posedge clk_i) begin
        dec_q <= dec_d;
    end

    always_comb begin
        dec_o       = dec_q;
        dec_o.valid = valid_q;
    end

    // Fetch never hands over a word while execute redirects
    a_flush_no_fetch: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        flush_i |-> !fetch_i.valid);

endmodule

`default_nettype wire

/* hdl/rv_execute.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_execute
    import rv_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  decode_s     dec_i,
    output logic        redirect_valid_o,
    output logic [31:0] redirect_pc_o,
    output logic        flush_o,
    output logic        wb_we_o,
    output logic [4:0]  wb_rd_o,
    output logic [31:0] wb_value_o,
    output retire_s     retire_o
);

    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [4:0]  shamt;
    logic [31:0] alu_res;
    logic [31:0] link;
    logic        taken;
    logic        valid_q;
    logic        we_q;
    logic        illegal_q;
    logic [31:0] pc_q;
    logic [4:0]  rd_q;
    logic [31:0] value_q;

    // Operand select
    assign op_a  = dec_i.a_is_pc  ? dec_i.pc  : dec_i.rs1_val;
    assign op_b  = dec_i.b_is_imm ? dec_i.imm : dec_i.rs2_val;
    assign shamt = op_b[4:0];
    assign link  = dec_i.pc + 32'd4;

    always_comb begin
        case (dec_i.alu_op)
            ALU_ADD:    alu_res = op_a + op_b;
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_SLL:    alu_res = op_a << shamt;
            ALU_SLT:    alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   alu_res = {31'b0, op_a < op_b};
            ALU_XOR:    alu_res = op_a ^ op_b;
            ALU_SRL:    alu_res = op_a >> shamt;
            ALU_SRA:    alu_res = $unsigned($signed(op_a) >>> shamt);
            ALU_OR:     alu_res = op_a | op_b;
            ALU_AND:    alu_res = op_a & op_b;
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = 32'b0;
        endcase
    end

    // Branch compare on the two register values
    always_comb begin
        case (dec_i.funct3)
            F3_BEQ:  taken = (dec_i.rs1_val == dec_i.rs2_val);
            F3_BNE:  taken = (dec_i.rs1_val != dec_i.rs2_val);
            F3_BLT:  taken = ($signed(dec_i.rs1_val) < $signed(dec_i.rs2_val));
            F3_BGE:  taken = ($signed(dec_i.rs1_val) >= $signed(dec_i.rs2_val));
            F3_BLTU: taken = (dec_i.rs1_val < dec_i.rs2_val);
            F3_BGEU: taken = (dec_i.rs1_val >= dec_i.rs2_val);
            default: taken = 1'b0;
        endcase
    end

    // Control transfer back to fetch
    assign redirect_valid_o = dec_i.valid &&
                              (dec_i.is_jal || dec_i.is_jalr || (dec_i.is_branch && taken));
    // JALR target has bit 0 forced low
    assign redirect_pc_o = dec_i.is_jalr ? ((dec_i.rs1_val + dec_i.imm) & ~32'd1)
                                         : (dec_i.pc + dec_i.imm);
    assign flush_o = redirect_valid_o;

    // Write-back, x0 never written
    assign wb_we_o    = dec_i.valid && dec_i.writes_rd && (dec_i.rd != 5'd0);
    assign wb_rd_o    = dec_i.rd;
    assign wb_value_o = (dec_i.is_jal || dec_i.is_jalr) ? link : alu_res;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q   <= 1'b0;
            we_q      <= 1'b0;
            illegal_q <= 1'b0;
        end else begin
            valid_q   <= dec_i.valid;
            we_q      <= wb_we_o;
            illegal_q <= dec_i.valid && dec_i.illegal;
        end
    end

    // Value reads zero when nothing was written
    always_ff @(posedge clk_i) begin
        pc_q    <= dec_i.pc;
        rd_q    <= dec_i.rd;
        value_q <= wb_we_o ? wb_value_o : 32'b0;
    end

    assign retire_o.valid   = valid_q;
    assign retire_o.pc      = pc_q;
    assign retire_o.rd      = rd_q;
    assign retire_o.value   = value_q;
    assign retire_o.we      = we_q;
    assign retire_o.illegal = illegal_q;

    // A redirect lasts one cycle since decode drops the word behind it
    a_redirect_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        redirect_valid_o |=> !redirect_valid_o);

endmodule

`default_nettype wire

/* hdl/rv_core_top.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_core_top
    import rv_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_n_i,
    output wb_req_s wb_req_o,
    input  wb_rsp_s wb_rsp_i,
    output retire_s retire_o
);

    fetch_s      fetch;
    decode_s     dec;
    logic        redirect_valid;
    logic [31:0] redirect_pc;
    logic        flush;
    logic [4:0]  rs1_addr;
    logic [4:0]  rs2_addr;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic        wb_we;
    logic [4:0]  wb_rd;
    logic [31:0] wb_value;

    // Instruction fetch over Wishbone
    rv_fetch u_fetch (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .redirect_valid_i (redirect_valid),
        .redirect_pc_i    (redirect_pc),
        .wb_rsp_i         (wb_rsp_i),
        .wb_req_o         (wb_req_o),
        .fetch_o          (fetch)
    );

    rv_decode u_decode (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .fetch_i    (fetch),
        .flush_i    (flush),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .wb_we_i    (wb_we),
        .wb_rd_i    (wb_rd),
        .wb_value_i (wb_value),
        .dec_o      (dec)
    );

    // Written by execute on the retire edge
    rv_regfile u_regfile (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .we_i       (wb_we),
        .rd_i       (wb_rd),
        .wd_i       (wb_value)
    );

    rv_execute u_execute (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .dec_i            (dec),
        .redirect_valid_o (redirect_valid),
        .redirect_pc_o    (redirect_pc),
        .flush_o          (flush),
        .wb_we_o          (wb_we),
        .wb_rd_o          (wb_rd),
        .wb_value_o       (wb_value),
        .retire_o         (retire_o)
    );

endmodule

`default_nettype wire

/* tests/tb_rv_program.svh */
// Instruction encoders, straight from the RV32I formats

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                      input logic [6:0] opc);
    return {imm, rd, opc};
endfunction

// Branch offset is in bytes, bit 0 dropped
function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                      input logic [4:0] rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
endfunction

// Address of the word about to be appended
function automatic logic [31:0] next_pc();
    return RESET_PC + 32'(4 * prog.size());
endfunction

// Word that retires with a register write
task automatic put_write(input logic [31:0] word, input logic [4:0] rd,
                         input logic [31:0] value);
    exp_q.push_back(retire_s'{1'b1, next_pc(), rd, value, 1'b1, 1'b0});
    prog.push_back(word);
endtask

// Word that retires without writing a register
task automatic put_nowrite(input logic [31:0] word, input logic illegal);
    exp_q.push_back(retire_s'{1'b1, next_pc(), 5'd0, 32'd0, 1'b0, illegal});
    prog.push_back(word);
endtask

// Word jumped over, must never retire
task automatic put_skipped(input logic [31:0] word);
    prog.push_back(word);
endtask

task automatic load_program();
    logic [31:0] poison;
    // Writes x15, which no other word touches
    poison = enc_i(12'd1, 5'd0, F3_ADD, 5'd15, OPC_OP_IMM);
    // 0x00 OP-IMM with a negative immediate, then LUI and AUIPC
    put_write(enc_i(12'hFFB, 5'd0, F3_ADD, 5'd1, OPC_OP_IMM), 5'd1, 32'hFFFF_FFFB);
    put_write(enc_i(12'd3, 5'd0, F3_ADD, 5'd2, OPC_OP_IMM), 5'd2, 32'd3);
    put_write(enc_u(20'h80000, 5'd3, OPC_LUI), 5'd3, 32'h8000_0000);
    put_write(enc_u(20'h00001, 5'd4, OPC_AUIPC), 5'd4, 32'h0000_100C);
    // 0x10 OP with x1 = -5, x2 = 3, x3 = 0x80000000
    put_write(enc_r(7'd0, 5'd2, 5'd1, F3_ADD, 5'd5, OPC_OP), 5'd5, 32'hFFFF_FFFE);
    put_write(enc_r(F7_ALT, 5'd2, 5'd5, F3_ADD, 5'd6, OPC_OP), 5'd6, 32'hFFFF_FFFB);
    put_write(enc_r(7'd0, 5'd2, 5'd2, F3_SLL, 5'd7, OPC_OP), 5'd7, 32'd24);
    put_write(enc_r(7'd0, 5'd2, 5'd1, F3_SLT, 5'd8, OPC_OP), 5'd8, 32'd1);
    put_write(enc_r(7'd0, 5'd2, 5'd1, F3_SLTU, 5'd9, OPC_OP), 5'd9, 32'd0);
    put_write(enc_r(7'd0, 5'd2, 5'd1, F3_XOR, 5'd10, OPC_OP), 5'd10, 32'hFFFF_FFF8);
    put_write(enc_r(7'd0, 5'd2, 5'd3, F3_SR, 5'd11, OPC_OP), 5'd11, 32'h1000_0000);
    put_write(enc_r(F7_ALT, 5'd2, 5'd3, F3_SR, 5'd12, OPC_OP), 5'd12, 32'hF000_0000);
    put_write(enc_r(7'd0, 5'd2, 5'd1, F3_OR, 5'd13, OPC_OP), 5'd13, 32'hFFFF_FFFB);
    put_write(enc_r(7'd0, 5'd2, 5'd1, F3_AND, 5'd14, OPC_OP), 5'd14, 32'd3);
    // 0x38 add into x0
    put_nowrite(enc_r(7'd0, 5'd2, 5'd1, F3_ADD, 5'd0, OPC_OP), 1'b0);
    // 0x3C each compare taken once over a poison word and once falling through
    put_nowrite(enc_b(F3_BEQ, 5'd2, 5'd14, 13'd8), 1'b0);
    put_skipped(poison);
    put_nowrite(enc_b(F3_BNE, 5'd2, 5'd14, 13'd8), 1'b0);
    put_nowrite(enc_b(F3_BNE, 5'd1, 5'd2, 13'd8), 1'b0);
    put_skipped(poison);
    put_nowrite(enc_b(F3_BLT, 5'd2, 5'd1, 13'd8), 1'b0);
    put_nowrite(enc_b(F3_BLT, 5'd1, 5'd2, 13'd8), 1'b0);
    put_skipped(poison);
    put_nowrite(enc_b(F3_BGE, 5'd1, 5'd2, 13'd8), 1'b0);
    put_nowrite(enc_b(F3_BGE, 5'd2, 5'd1, 13'd8), 1'b0);
    put_skipped(poison);
    put_nowrite(enc_b(F3_BLTU, 5'd1, 5'd2, 13'd8), 1'b0);
    put_nowrite(enc_b(F3_BLTU, 5'd2, 5'd1, 13'd8), 1'b0);
    put_skipped(poison);
    put_nowrite(enc_b(F3_BGEU, 5'd2, 5'd1, 13'd8), 1'b0);
    put_nowrite(enc_b(F3_BGEU, 5'd1, 5'd2, 13'd8), 1'b0);
    put_skipped(poison);
    // 0x80 JAL to 0x8C, JALR to 0x99 with bit 0 cleared
    put_write(enc_j(21'd12, 5'd16), 5'd16, 32'h0000_0084);
    put_skipped(poison);
    put_skipped(poison);
    put_write(enc_i(12'd21, 5'd16, 3'b000, 5'd18, OPC_JALR), 5'd18, 32'h0000_0090);
    put_skipped(poison);
    put_skipped(poison);
    // 0x98 load to x5, store, unknown opcode aimed at x6
    put_nowrite(enc_i(12'd0, 5'd0, 3'b010, 5'd5, OPC_LOAD), 1'b1);
    put_nowrite(enc_r(7'd0, 5'd5, 5'd0, 3'b010, 5'd0, OPC_STORE), 1'b1);
    put_nowrite(enc_i(12'd0, 5'd0, 3'b000, 5'd6, 7'h7F), 1'b1);
    // 0xA4 x5 and x6 still hold their OP results
    put_write(enc_i(12'd0, 5'd5, F3_ADD, 5'd19, OPC_OP_IMM), 5'd19, 32'hFFFF_FFFE);
    put_write(enc_r(7'd0, 5'd0, 5'd6, F3_ADD, 5'd20, OPC_OP), 5'd20, 32'hFFFF_FFFB);
    // 0xAC jump to itself, seen retiring twice
    put_nowrite(enc_j(21'd0, 5'd0), 1'b0);
    exp_q.push_back(exp_q[exp_q.size() - 1]);
endtask

/* tests/tb_rv_core.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_rv_core
    import rv_pkg::*;
();

    logic        clk = 1'b0;
    logic        rst_n;
    wb_req_s     wb_req;
    wb_rsp_s     wb_rsp = '0;
    retire_s     retire;

    // Program words and the expected retire order
    logic [31:0] prog[$];
    retire_s     exp_q[$];

    int          err_retire = 0;
    int          err_bus = 0;

    // Memory model state
    logic [31:0] rng_state = 32'd45;
    logic        armed = 1'b0;
    logic [1:0]  delay_left = 2'd0;

    // Bus monitor state
    logic        first_seen = 1'b0;
    logic        req_pending = 1'b0;
    wb_req_s     held_req = '0;

`include "tb_rv_program.svh"

    rv_core_top DUT (
        .clk_i    (clk),
        .rst_n_i  (rst_n),
        .wb_req_o (wb_req),
        .wb_rsp_i (wb_rsp),
        .retire_o (retire)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] mem_word(input logic [31:0] adr);
        int idx;
        idx = int'(adr[31:2]);
        if (idx < prog.size()) begin
            return prog[idx];
        end
        // Past the program the word follows the full address
        return ~adr;
    endfunction

    task automatic check_wb(input wb_req_s act, input wb_req_s exp, input logic use_adr,
                            input string msg);
        if (act.cyc !== exp.cyc || act.stb !== exp.stb || (use_adr && act.adr !== exp.adr)) begin
            err_bus++;
            $display("CHECK FAILED at %0t: %s, got cyc %b stb %b adr %h, expected %b %b %h",
                     $time, msg, act.cyc, act.stb, act.adr, exp.cyc, exp.stb, exp.adr);
        end
    endtask

    // rd and value only carry meaning for a register write
    task automatic check_retire(input retire_s act, input retire_s exp, input int idx);
        if (act.pc !== exp.pc || act.we !== exp.we || act.illegal !== exp.illegal ||
            (exp.we && (act.rd !== exp.rd || act.value !== exp.value))) begin
            err_retire++;
            $display("CHECK FAILED at %0t: retire %0d got pc %h rd %0d value %h we %b ill %b",
                     $time, idx, act.pc, act.rd, act.value, act.we, act.illegal);
            $display("  expected pc %h rd %0d value %h we %b ill %b",
                     exp.pc, exp.rd, exp.value, exp.we, exp.illegal);
        end
    endtask

    // Wishbone slave, ack after 0 to 3 wait cycles, held for one cycle
    always @(posedge clk) begin
        if (!rst_n) begin
            wb_rsp <= '0;
            armed = 1'b0;
        end else if (wb_rsp.ack) begin
            wb_rsp <= '0;
            armed = 1'b0;
        end else if (wb_req.cyc && wb_req.stb) begin
            if (!armed) begin
                armed = 1'b1;
                rng_state = xorshift32(rng_state);
                delay_left = rng_state[1:0];
            end
            if (delay_left == 2'd0) begin
                wb_rsp.ack <= 1'b1;
                wb_rsp.dat <= mem_word(wb_req.adr);
            end else begin
                delay_left = delay_left - 2'd1;
            end
        end
    end

    // Request must hold until ack, first one at the reset vector
    always @(posedge clk) begin
        if (rst_n) begin
            if (req_pending) begin
                check_wb(wb_req, held_req, 1'b1, "request changed before ack");
            end
            if (!first_seen && wb_req.stb) begin
                check_wb(wb_req, wb_req_s'{1'b1, 1'b1, RESET_PC}, 1'b1,
                         "first request not at reset vector");
                first_seen = 1'b1;
            end
            req_pending = wb_req.stb && !wb_rsp.ack;
            held_req    = wb_req;
        end
    end

    initial begin
        load_program();
        rst_n <= 1'b0;
        repeat (5) begin
            @(posedge clk);
            check_wb(wb_req, wb_req_s'(0), 1'b0, "bus active during reset");
        end
        rst_n <= 1'b1;
        // Walk the expected retire sequence
        for (int i = 0; i < exp_q.size(); i++) begin
            @(posedge clk);
            while (retire.valid !== 1'b1) begin
                @(posedge clk);
            end
            check_retire(retire, exp_q[i], i);
        end
        $display("Errors: %0d retire, %0d bus", err_retire, err_bus);
        if (err_retire == 0 && err_bus == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // Budget of 20 cycles per expected retire plus reset
    initial begin
        #1;
        repeat (20 * exp_q.size() + 10) @(posedge clk);
        $display("Timeout: the retire sequence did not complete in time");
        $display("Errors: %0d retire, %0d bus", err_retire, err_bus);
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+tests
hdl/rv_pkg.sv
hdl/rv_regfile.sv
hdl/rv_fetch.sv
hdl/rv_decode.sv
hdl/rv_execute.sv
hdl/rv_core_top.sv
tests/tb_rv_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the RV32I core testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -f vlog.f --top-module tb_rv_core \
    -Mdir "$BUILD_DIR" -o sim_tb_rv_core > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/sim_tb_rv_core" > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# The log decides pass or fail
if grep -q "Test FAILED" "$SIM_LOG"; then
    exit 1
fi
exit 0
